// File: vlog.f
ahb_axi_pkg.sv
ahb_addr_check.sv
bridge_fsm.sv
axi_cmd_buf.sv
ahb_to_axi4_top.sv
tb_clk_gen.sv
tb_ahb_to_axi4.sv

// File: Makefile
# Verilator simulation of the AHB-Lite to AXI4 bridge

VERILATOR ?= verilator
TOP       ?= tb_ahb_to_axi4
FLIST     ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb_ahb_to_axi4.sv
// Testbench for the AHB-Lite to AXI4 bridge with AHB master driver and AXI slave model
`timescale 1ns/100ps

module tb_ahb_to_axi4;
   import ahb_axi_pkg::*;

   localparam int CLK_PERIOD   = 20;
   localparam int DRV_DLY      = 1;                       // Input drive delay after the edge
   localparam int MAX_DLY      = 3;                       // Largest slave ready or rvalid delay
   localparam int N_RAND       = 40;                      // Random transfers in test 6
   localparam int TOTAL_XFERS  = 15 + 6 + 6 + 1 + N_RAND;
   localparam int CYC_PER_XFER = 4 * (MAX_DLY + 2) + 8;   // Worst case per transfer
   localparam int TIMEOUT_NS   = (TOTAL_XFERS * CYC_PER_XFER + 20) * CLK_PERIOD;

   typedef struct packed {
      logic      err;      // Transfer must end in an AHB error
      logic      write;
      haddr_t    addr;
      hsize_t    size;
      wstrb_t    strb;
      bus_data_t data;
   } cmd_t;

   logic      bus_clk;
   logic      rst_n;
   haddr_t    ahb_haddr;
   hsize_t    ahb_hsize;
   htrans_t   ahb_htrans;
   logic      ahb_hwrite;
   bus_data_t ahb_hwdata;
   logic      ahb_hsel;
   logic      ahb_hreadyin;
   bus_data_t ahb_hrdata;
   logic      ahb_hreadyout;
   logic      ahb_hresp;
   logic      axi_awvalid;
   logic      axi_awready;
   haddr_t    axi_awaddr;
   hsize_t    axi_awsize;
   logic      axi_wvalid;
   logic      axi_wready;
   bus_data_t axi_wdata;
   wstrb_t    axi_wstrb;
   logic      axi_arvalid;
   logic      axi_arready;
   haddr_t    axi_araddr;
   hsize_t    axi_arsize;
   logic      axi_rvalid;
   bus_data_t axi_rdata;
   axi_resp_t axi_rresp;
   bus_data_t slave_rdata;          // Data of the last read the slave answered

   cmd_t        exp_q[$];           // Commands the reference predicts
   cmd_t        obs_q[$];           // Commands seen by the slave model
   logic [31:0] lfsr = 32'he845_358b;
   logic        rd_err_mode = 1'b0; // Slave answers reads with SLVERR
   int          err_cnt = 0;
   int          check_cnt = 0;
   int          test_cnt = 0;
   int          test_err_base = 0;

   tb_clk_gen #(.PERIOD_NS(CLK_PERIOD), .RST_CYCLES(3)) i_clk_gen (
      .bus_clk (bus_clk),
      .rst_n   (rst_n)
   );

   ahb_to_axi4_top i_dut (.*);

   // ***********************************************************
   // Random source and reference model
   // ***********************************************************
   // Fibonacci LFSR with taps 32 22 2 1
   function automatic logic [31:0] next_lfsr(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic bus_data_t take_bits(input int n);
      bus_data_t v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = next_lfsr(lfsr);
         v    = {v[62:0], lfsr[0]};   // One step per bit
      end
      return v;
   endfunction

   // Expected command and error outcome of one AHB transfer
   function automatic cmd_t ref_cmd(input haddr_t a, input hsize_t s, input logic w,
                                    input bus_data_t d);
      cmd_t c;
      int   nb;
      int   off;
      logic dccm;
      logic iccm;
      c.write = w;
      c.addr  = a;
      c.size  = s;
      c.strb  = '0;
      c.data  = w ? d : '0;
      dccm    = a[31:16] == DCCM_BASE[31:16];
      iccm    = a[31:16] == ICCM_BASE[31:16];
      nb      = 1 << int'(s);            // Bytes in the transfer
      off     = int'(a[2:0]);
      c.err   = !(dccm || iccm) || ((iccm || (dccm && w)) && nb < 4) || (off % nb != 0);
      if (w) begin
         for (int i = 0; i < 8; i++) begin
            if (i >= off && i < off + nb) c.strb[i] = 1'b1;
         end
      end
      return c;
   endfunction

   // ***********************************************************
   // Compare tasks
   // ***********************************************************
   task automatic report(input string msg);
      $display("%s", msg);
      err_cnt++;
   endtask

   task automatic check_cmd(input logic wr, input haddr_t ea, input haddr_t ga,
                            input hsize_t es, input hsize_t gs, input wstrb_t eb,
                            input wstrb_t gb, input bus_data_t ed, input bus_data_t gd);
      check_cnt++;
      if (ea !== ga) report($sformatf("FAIL %s exp=%h got=%h", wr ? "awaddr" : "araddr", ea, ga));
      if (es !== gs) report($sformatf("FAIL %s exp=%h got=%h", wr ? "awsize" : "arsize", es, gs));
      if (wr && eb !== gb) report($sformatf("FAIL wstrb exp=%h got=%h", eb, gb));
      if (wr && ed !== gd) report($sformatf("FAIL wdata exp=%h got=%h", ed, gd));
   endtask

   task automatic check_rdata(input bus_data_t e, input bus_data_t g);
      check_cnt++;
      if (e !== g) report($sformatf("FAIL hrdata exp=%h got=%h", e, g));
   endtask

   task automatic check_resp(input logic e, input logic g);
      check_cnt++;
      if (e !== g) report($sformatf("FAIL hresp exp=%h got=%h", e, g));
   endtask

   task automatic check_flag(input string name, input logic e, input logic g);
      check_cnt++;
      if (e !== g) report($sformatf("FAIL %s exp=%h got=%h", name, e, g));
   endtask

   task automatic end_test(input string name);
      test_cnt++;
      $display("Test %0d %s: done, %0d errors", test_cnt, name, err_cnt - test_err_base);
      test_err_base = err_cnt;
   endtask

   // ***********************************************************
   // AHB master driver
   // ***********************************************************
   // Called just after a rising edge and returns at the closing edge
   task automatic ahb_xfer(input haddr_t a, input hsize_t s, input logic w,
                           input bus_data_t d);
      cmd_t c;
      logic rdy;
      logic rsp;
      logic saw_first;
      bus_data_t rd;
      c = ref_cmd(a, s, w, d);
      if (!c.err) exp_q.push_back(c);
      #DRV_DLY;
      ahb_haddr  = a;
      ahb_hsize  = s;
      ahb_hwrite = w;
      ahb_htrans = HTRANS_NONSEQ;
      do begin                              // Address phase
         @(negedge bus_clk);
         rdy = ahb_hreadyout;
         @(posedge bus_clk);
      end while (!rdy);
      #DRV_DLY;
      ahb_htrans = HTRANS_IDLE;
      ahb_hwdata = w ? d : '0;
      saw_first  = 1'b0;
      do begin                              // Data phase sampled mid-cycle
         @(negedge bus_clk);
         rdy = ahb_hreadyout;
         rsp = ahb_hresp;
         rd  = ahb_hrdata;
         if (rsp && !rdy) begin
            if (saw_first) report("Error response stalled for more than one cycle");
            saw_first = 1'b1;
         end else if (!rsp && saw_first) begin
            report("Error response dropped after its first cycle");
         end
         @(posedge bus_clk);
      end while (!rdy);
      if (rsp && !saw_first) report("Error response closed without a stalled first cycle");
      check_resp(c.err | (!w & rd_err_mode), rsp);
      if (!w && !rsp) check_rdata(slave_rdata, rd);
   endtask

   // ***********************************************************
   // AXI slave model
   // ***********************************************************
   initial begin
      logic nx_aw;
      logic nx_ar;
      logic nx_rv;
      logic armed;
      logic rd_pend;
      int   wait_cnt;
      int   rd_cnt;
      cmd_t o;
      axi_awready = 1'b0;
      axi_wready  = 1'b0;
      axi_arready = 1'b0;
      axi_rvalid  = 1'b0;
      axi_rdata   = '0;
      axi_rresp   = '0;
      slave_rdata = '0;
      armed       = 1'b0;
      rd_pend     = 1'b0;
      wait_cnt    = 0;
      rd_cnt      = 0;
      forever begin
         @(negedge bus_clk);
         nx_aw = 1'b0;
         nx_ar = 1'b0;
         nx_rv = 1'b0;
         if (rst_n) begin
            if (axi_awvalid && axi_arvalid) report("Write and read commands outstanding together");
            if (axi_awvalid !== axi_wvalid) report("awvalid and wvalid differ");
            if (!axi_rvalid && rd_pend) begin
               if (rd_cnt == 0) begin
                  nx_rv   = 1'b1;
                  rd_pend = 1'b0;
               end else begin
                  rd_cnt--;
               end
            end
            o = '0;
            if (axi_awvalid && axi_awready) begin        // Write handshake at next edge
               o.write = 1'b1;
               o.addr  = axi_awaddr;
               o.size  = axi_awsize;
               o.strb  = axi_wstrb;
               o.data  = axi_wdata;
               obs_q.push_back(o);
            end else if (axi_arvalid && axi_arready) begin
               o.addr  = axi_araddr;
               o.size  = axi_arsize;
               obs_q.push_back(o);
               rd_pend     = 1'b1;
               rd_cnt      = int'(take_bits(2));
               slave_rdata = take_bits(64);
            end else if (axi_awvalid || axi_arvalid) begin
               if (!armed) begin
                  armed    = 1'b1;
                  wait_cnt = int'(take_bits(2));   // Ready delay 0..3
               end
               if (wait_cnt == 0) begin
                  armed = 1'b0;
                  nx_aw = axi_awvalid;
                  nx_ar = axi_arvalid;
               end else begin
                  wait_cnt--;
               end
            end
         end
         @(posedge bus_clk);
         #DRV_DLY;
         axi_awready = nx_aw;
         axi_wready  = nx_aw;
         axi_arready = nx_ar;
         axi_rvalid  = nx_rv;
         axi_rdata   = nx_rv ? slave_rdata : '0;
         axi_rresp   = (nx_rv && rd_err_mode) ? 2'b10 : 2'b00;
      end
   end

   // Match each logged command against the oldest prediction
   always @(posedge bus_clk) begin
      cmd_t e;
      cmd_t g;
      while (obs_q.size() > 0) begin
         g = obs_q.pop_front();
         if (exp_q.size() == 0) begin
            report($sformatf("AXI command to %h issued with none expected", g.addr));
         end else begin
            e = exp_q.pop_front();
            if (e.write !== g.write) report("AXI command has the wrong direction");
            else check_cmd(g.write, e.addr, g.addr, e.size, g.size, e.strb, g.strb,
                           e.data, g.data);
         end
      end
   end

   // Watchdog
   initial begin
      #(TIMEOUT_NS);
      $display("Watchdog expired, the DUT stopped responding");
      $display("TEST FAILED");
      $finish;
   end

   // ***********************************************************
   // Test sequence
   // ***********************************************************
   initial begin
      haddr_t a;
      logic   w;
      hsize_t s;
      ahb_haddr    = '0;
      ahb_hsize    = '0;
      ahb_htrans   = HTRANS_IDLE;
      ahb_hwrite   = 1'b0;
      ahb_hwdata   = '0;
      ahb_hsel     = 1'b1;
      ahb_hreadyin = 1'b1;
      wait (rst_n);
      @(negedge bus_clk);
      check_flag("awvalid", 1'b0, axi_awvalid);
      check_flag("wvalid", 1'b0, axi_wvalid);
      check_flag("arvalid", 1'b0, axi_arvalid);
      check_resp(1'b0, ahb_hresp);
      check_flag("hreadyout", 1'b1, ahb_hreadyout);
      @(posedge bus_clk);
      end_test("reset values");

      for (int sz = 0; sz < 4; sz++) begin         // Every size at every aligned offset
         for (int off = 0; off < 8; off += (1 << sz)) begin
            ahb_xfer(DCCM_BASE + 32'h80 + haddr_t'(off), hsize_t'(sz), 1'b1, take_bits(64));
         end
      end
      end_test("DCCM writes");

      ahb_xfer(DCCM_BASE + 32'h100, HSIZE_WORD, 1'b0, '0);
      ahb_xfer(DCCM_BASE + 32'h208, HSIZE_DWORD, 1'b0, '0);
      ahb_xfer(DCCM_BASE + 32'h13, HSIZE_BYTE, 1'b0, '0);
      ahb_xfer(DCCM_BASE + 32'h16, HSIZE_HALF, 1'b0, '0);
      ahb_xfer(ICCM_BASE + 32'h40, HSIZE_WORD, 1'b0, '0);
      ahb_xfer(ICCM_BASE + 32'hFFF8, HSIZE_DWORD, 1'b0, '0);
      end_test("CCM reads");

      ahb_xfer(32'h1000_0000, HSIZE_WORD, 1'b1, 64'h1234);     // Outside both windows
      ahb_xfer(32'hF005_0000, HSIZE_WORD, 1'b0, '0);
      ahb_xfer(DCCM_BASE + 32'h2, HSIZE_WORD, 1'b0, '0);       // Misaligned
      ahb_xfer(DCCM_BASE + 32'h4, HSIZE_DWORD, 1'b1, 64'h55);
      ahb_xfer(ICCM_BASE + 32'h10, HSIZE_HALF, 1'b0, '0);      // Short ICCM access
      ahb_xfer(DCCM_BASE + 32'h1, HSIZE_BYTE, 1'b1, 64'hAA);   // Short DCCM write
      end_test("address errors");

      rd_err_mode = 1'b1;
      ahb_xfer(DCCM_BASE + 32'h300, HSIZE_WORD, 1'b0, '0);
      rd_err_mode = 1'b0;
      end_test("read error");

      for (int i = 0; i < N_RAND; i++) begin
         w = take_bits(1) != 0;
         s = take_bits(1) != 0 ? HSIZE_DWORD : HSIZE_WORD;
         a = (take_bits(1) != 0) ? ICCM_BASE : DCCM_BASE;
         a = a | (haddr_t'(take_bits(13)) << 3);
         if (s == HSIZE_WORD && take_bits(1) != 0) a = a | 32'h4;
         ahb_xfer(a, s, w, take_bits(64));
      end
      end_test("random traffic");

      repeat (4 * (MAX_DLY + 2)) @(posedge bus_clk);
      if (exp_q.size() != 0) report($sformatf("%0d expected AXI commands never appeared",
                                              exp_q.size()));
      $display("Summary: %0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

// File: tb_clk_gen.sv
// Testbench clock and synchronous reset generator for the bridge
`timescale 1ns/100ps

module tb_clk_gen #(
   parameter int PERIOD_NS  = 20,   // Clock period
   parameter int RST_CYCLES = 3     // Cycles with rst_n low
) (
   output logic bus_clk,
   output logic rst_n
);

   initial bus_clk = 1'b0;
   always #(PERIOD_NS / 2) bus_clk = ~bus_clk;

   // Release just after an edge so the DUT sees a clean deassertion
   initial begin
      rst_n = 1'b0;
      repeat (RST_CYCLES) @(posedge bus_clk);
      #1 rst_n = 1'b1;
   end

endmodule

// File: ahb_to_axi4_top.sv
// AHB-Lite slave to single-beat AXI4 master bridge top level
`timescale 1ns/100ps

module ahb_to_axi4_top (
   input  logic                   bus_clk,
   input  logic                   rst_n,

   // AHB-Lite slave side
   input  ahb_axi_pkg::haddr_t    ahb_haddr,
   input  ahb_axi_pkg::hsize_t    ahb_hsize,
   input  ahb_axi_pkg::htrans_t   ahb_htrans,
   input  logic                   ahb_hwrite,
   input  ahb_axi_pkg::bus_data_t ahb_hwdata,
   input  logic                   ahb_hsel,
   input  logic                   ahb_hreadyin,
   output ahb_axi_pkg::bus_data_t ahb_hrdata,
   output logic                   ahb_hreadyout,
   output logic                   ahb_hresp,       // High on error

   // AXI4 write address and data
   output logic                   axi_awvalid,
   input  logic                   axi_awready,
   output ahb_axi_pkg::haddr_t    axi_awaddr,
   output ahb_axi_pkg::hsize_t    axi_awsize,
   output logic                   axi_wvalid,
   input  logic                   axi_wready,      // Slave accepts W with AW
   output ahb_axi_pkg::bus_data_t axi_wdata,
   output ahb_axi_pkg::wstrb_t    axi_wstrb,

   // AXI4 read address and data
   output logic                   axi_arvalid,
   input  logic                   axi_arready,
   output ahb_axi_pkg::haddr_t    axi_araddr,
   output ahb_axi_pkg::hsize_t    axi_arsize,
   input  logic                   axi_rvalid,      // rready is always high at the slave
   input  ahb_axi_pkg::bus_data_t axi_rdata,
   input  ahb_axi_pkg::axi_resp_t axi_rresp
);
   import ahb_axi_pkg::*;

   haddr_t addr_q;           // Registered address phase
   hsize_t size_q;
   logic   write_q;
   wstrb_t wstrb;
   logic   addr_err;
   logic   trans_busy;
   logic   hready_acc;
   logic   cmd_wr_en;
   logic   cmd_drop;
   logic   cmd_full;
   logic   cmd_write;

   // ***********************************************************
   // Address phase and map check
   // ***********************************************************
   ahb_addr_check i_addr_check (
      .bus_clk        (bus_clk),
      .rst_n          (rst_n),
      .ahb_haddr      (ahb_haddr),
      .ahb_hsize      (ahb_hsize),
      .ahb_htrans     (ahb_htrans),
      .ahb_hwrite     (ahb_hwrite),
      .ahb_hsel       (ahb_hsel),
      .ahb_hready_acc (hready_acc),
      .addr_q         (addr_q),
      .size_q         (size_q),
      .write_q        (write_q),
      .wstrb          (wstrb),
      .addr_err       (addr_err),
      .trans_busy     (trans_busy)
   );

   // Transfer sequencing and read return
   bridge_fsm i_fsm (
      .bus_clk        (bus_clk),
      .rst_n          (rst_n),
      .ahb_htrans     (ahb_htrans),
      .ahb_hsel       (ahb_hsel),
      .ahb_hwrite     (ahb_hwrite),
      .ahb_hreadyin   (ahb_hreadyin),
      .addr_err       (addr_err),
      .trans_busy     (trans_busy),
      .cmd_full       (cmd_full),
      .cmd_write      (cmd_write),
      .axi_rvalid     (axi_rvalid),
      .axi_rdata      (axi_rdata),
      .axi_rresp      (axi_rresp),
      .ahb_hready_acc (hready_acc),
      .ahb_hreadyout  (ahb_hreadyout),
      .ahb_hresp      (ahb_hresp),
      .ahb_hrdata     (ahb_hrdata),
      .cmd_wr_en      (cmd_wr_en),
      .cmd_drop       (cmd_drop)
   );

   // ***********************************************************
   // AXI command buffer
   // ***********************************************************
   axi_cmd_buf i_cmd_buf (
      .bus_clk     (bus_clk),
      .rst_n       (rst_n),
      .cmd_wr_en   (cmd_wr_en),
      .cmd_drop    (cmd_drop),
      .addr_q      (addr_q),
      .size_q      (size_q),
      .write_q     (write_q),
      .wstrb       (wstrb),
      .ahb_hwdata  (ahb_hwdata),
      .axi_awready (axi_awready),
      .axi_arready (axi_arready),
      .cmd_full    (cmd_full),
      .cmd_write   (cmd_write),
      .axi_awvalid (axi_awvalid),
      .axi_awaddr  (axi_awaddr),
      .axi_awsize  (axi_awsize),
      .axi_wvalid  (axi_wvalid),
      .axi_wdata   (axi_wdata),
      .axi_wstrb   (axi_wstrb),
      .axi_arvalid (axi_arvalid),
      .axi_araddr  (axi_araddr),
      .axi_arsize  (axi_arsize)
   );

endmodule

// File: axi_cmd_buf.sv
// One-entry AXI command buffer driving the write-address, write-data and read-address channels
`timescale 1ns/100ps

module axi_cmd_buf (
   input  logic                   bus_clk,
   input  logic                   rst_n,
   input  logic                   cmd_wr_en,
   input  logic                   cmd_drop,
   input  ahb_axi_pkg::haddr_t    addr_q,
   input  ahb_axi_pkg::hsize_t    size_q,
   input  logic                   write_q,
   input  ahb_axi_pkg::wstrb_t    wstrb,
   input  ahb_axi_pkg::bus_data_t ahb_hwdata,
   input  logic                   axi_awready,
   input  logic                   axi_arready,
   output logic                   cmd_full,
   output logic                   cmd_write,
   output logic                   axi_awvalid,
   output ahb_axi_pkg::haddr_t    axi_awaddr,
   output ahb_axi_pkg::hsize_t    axi_awsize,
   output logic                   axi_wvalid,
   output ahb_axi_pkg::bus_data_t axi_wdata,
   output ahb_axi_pkg::wstrb_t    axi_wstrb,
   output logic                   axi_arvalid,
   output ahb_axi_pkg::haddr_t    axi_araddr,
   output ahb_axi_pkg::hsize_t    axi_arsize
);
   import ahb_axi_pkg::*;

   logic      buf_vld;
   logic      buf_write;      // Direction of the held command
   hsize_t    buf_size;
   haddr_t    buf_addr;
   wstrb_t    buf_wstrb;
   bus_data_t buf_wdata;
   logic      accept;         // Slave took the entry this cycle
   logic      buf_clr;

   // ***********************************************************
   // Entry control
   // ***********************************************************
   // AW and W leave together, so awready alone frees a write
   assign accept  = (axi_awvalid & axi_awready) | (axi_arvalid & axi_arready);
   assign buf_clr = (accept & ~cmd_wr_en) | cmd_drop;  // A same-cycle load keeps it valid

   assign cmd_full  = buf_vld & ~accept;
   assign cmd_write = buf_write;

   always_ff @(posedge bus_clk) begin
      if (!rst_n) begin
         buf_vld   <= 1'b0;
         buf_write <= 1'b0;
      end else begin
         if (buf_clr) begin
            buf_vld <= 1'b0;
         end else if (cmd_wr_en) begin
            buf_vld <= 1'b1;
         end
         if (cmd_wr_en) begin
            buf_write <= write_q;
         end
      end
   end

   // Command payload
   always_ff @(posedge bus_clk) begin
      if (cmd_wr_en) begin
         buf_size  <= size_q;
         buf_addr  <= addr_q;
         buf_wstrb <= wstrb;
         buf_wdata <= ahb_hwdata;   // Write data phase is live in this cycle
      end
   end

   // ***********************************************************
   // AXI channel steering
   // ***********************************************************
   assign axi_awvalid = buf_vld & buf_write;
   assign axi_awaddr  = buf_addr;
   assign axi_awsize  = buf_size;

   assign axi_wvalid  = buf_vld & buf_write;   // Tied to AW
   assign axi_wdata   = buf_wdata;
   assign axi_wstrb   = buf_wstrb;

   assign axi_arvalid = buf_vld & ~buf_write;
   assign axi_araddr  = buf_addr;
   assign axi_arsize  = buf_size;

endmodule

// File: bridge_fsm.sv
// Bridge transfer FSM with AHB ready and response generation and the read-data return buffer
`timescale 1ns/100ps

module bridge_fsm (
   input  logic                   bus_clk,
   input  logic                   rst_n,
   input  ahb_axi_pkg::htrans_t   ahb_htrans,
   input  logic                   ahb_hsel,
   input  logic                   ahb_hwrite,
   input  logic                   ahb_hreadyin,   // Bus-wide ready from the interconnect
   input  logic                   addr_err,       // Map violation of the data-phase transfer
   input  logic                   trans_busy,
   input  logic                   cmd_full,
   input  logic                   cmd_write,
   input  logic                   axi_rvalid,
   input  ahb_axi_pkg::bus_data_t axi_rdata,
   input  ahb_axi_pkg::axi_resp_t axi_rresp,
   output logic                   ahb_hready_acc,
   output logic                   ahb_hreadyout,
   output logic                   ahb_hresp,
   output ahb_axi_pkg::bus_data_t ahb_hrdata,
   output logic                   cmd_wr_en,      // One-cycle command load
   output logic                   cmd_drop        // Clears a held read on error
);
   import ahb_axi_pkg::*;

   typedef enum logic [1:0] {
      IDLE = 2'b00,   // No transfer in its data phase
      WR   = 2'b01,   // Write data phase
      RD   = 2'b10,   // Read waiting to load the buffer
      PEND = 2'b11    // Read issued, waiting on rvalid
   } state_t;

   state_t    state;
   state_t    state_nxt;
   logic      state_en;
   logic      rdata_en;       // Capture read return
   logic      read_err_in;
   logic      read_err;       // High for one cycle after a failed read
   logic      hresp_q;
   logic      hready_q;
   logic      err_second;     // Second cycle of a two-cycle error
   bus_data_t rdata_q;

   // ***********************************************************
   // Next state
   // ***********************************************************
   always_comb begin
      state_nxt   = IDLE;
      state_en    = 1'b0;
      rdata_en    = 1'b0;
      read_err_in = 1'b0;
      cmd_wr_en   = 1'b0;
      case (state)
         IDLE: begin
            state_nxt = ahb_hwrite ? WR : RD;
            state_en  = ahb_hready_acc & ahb_htrans[1] & ahb_hsel;  // Real transfer only
         end
         WR: begin
            // Back-to-back transfers chain straight from the write data phase
            if (ahb_hresp | (ahb_htrans == HTRANS_IDLE) | ~ahb_hsel) begin
               state_nxt = IDLE;
            end else begin
               state_nxt = ahb_hwrite ? WR : RD;
            end
            state_en  = ~cmd_full | ahb_hresp;
            cmd_wr_en = ~cmd_full & ~(ahb_hresp | trans_busy);  // hwdata live now
         end
         RD: begin
            state_nxt = ahb_hresp ? IDLE : PEND;
            state_en  = ~cmd_full | ahb_hresp;
            cmd_wr_en = ~cmd_full & ~ahb_hresp;
         end
         PEND: begin
            state_nxt   = IDLE;              // Data goes out next cycle
            state_en    = axi_rvalid & ~cmd_write;
            rdata_en    = state_en;
            read_err_in = state_en & (|axi_rresp);
         end
         default: begin
            state_nxt = IDLE;
         end
      endcase
   end

   // ***********************************************************
   // AHB response
   // ***********************************************************
   assign err_second = hresp_q & ~hready_q;

   assign ahb_hresp = (addr_err & (state != IDLE))  // Bad transfer in data phase
                    | read_err                      // AXI read error
                    | err_second;                   // Hold for the closing cycle

   // Low on the first error cycle, high on the second
   // Otherwise stall reads and writes that find the buffer busy
   assign ahb_hreadyout = ahb_hresp ? err_second
                        : ((state == IDLE) | ((state == WR) & ~cmd_full));

   assign ahb_hready_acc = ahb_hreadyout & ahb_hreadyin;
   assign ahb_hrdata     = rdata_q;
   assign cmd_drop       = ahb_hresp & ~cmd_write;

   // ***********************************************************
   // State and response history
   // ***********************************************************
   always_ff @(posedge bus_clk) begin
      if (!rst_n) begin
         state    <= IDLE;
         read_err <= 1'b0;
         hresp_q  <= 1'b0;
         hready_q <= 1'b0;
      end else begin
         if (state_en) begin
            state <= state_nxt;
         end
         read_err <= read_err_in;
         hresp_q  <= ahb_hresp;
         hready_q <= ahb_hready_acc;
      end
   end

   // Read return holding register
   always_ff @(posedge bus_clk) begin
      if (rdata_en) begin
         rdata_q <= axi_rdata;
      end
   end

endmodule

// File: ahb_addr_check.sv
// AHB address-phase capture with CCM window decode, size and alignment check and byte strobes
`timescale 1ns/100ps

module ahb_addr_check (
   input  logic                 bus_clk,
   input  logic                 rst_n,
   input  ahb_axi_pkg::haddr_t  ahb_haddr,       // Address phase inputs
   input  ahb_axi_pkg::hsize_t  ahb_hsize,
   input  ahb_axi_pkg::htrans_t ahb_htrans,
   input  logic                 ahb_hwrite,
   input  logic                 ahb_hsel,
   input  logic                 ahb_hready_acc,  // Address phase taken this cycle
   output ahb_axi_pkg::haddr_t  addr_q,
   output ahb_axi_pkg::hsize_t  size_q,
   output logic                 write_q,
   output ahb_axi_pkg::wstrb_t  wstrb,
   output logic                 addr_err,        // Registered transfer breaks the map
   output logic                 trans_busy
);
   import ahb_axi_pkg::*;

   htrans_t htrans_q;     // Type of the transfer now in its data phase
   logic    addr_en;      // Load for address, size and direction
   logic    in_dccm;
   logic    in_iccm;
   logic    size_err;
   logic    align_err;

   // ***********************************************************
   // Address phase registers
   // ***********************************************************
   assign addr_en = ahb_hready_acc & ahb_htrans[1];  // NONSEQ or SEQ only

   always_ff @(posedge bus_clk) begin
      if (addr_en) begin
         addr_q  <= ahb_haddr;
         size_q  <= ahb_hsize;
         write_q <= ahb_hwrite;
      end
   end

   // Transfer type is forced to IDLE when another slave is selected
   always_ff @(posedge bus_clk) begin
      if (!rst_n) begin
         htrans_q <= HTRANS_IDLE;
      end else if (ahb_hready_acc) begin
         htrans_q <= ahb_hsel ? ahb_htrans : HTRANS_IDLE;
      end
   end

   assign trans_busy = ahb_hsel & (ahb_htrans == HTRANS_BUSY);  // Master holding write data

   // ***********************************************************
   // Address map rules
   // ***********************************************************
   assign in_dccm = (addr_q & CCM_MASK) == DCCM_BASE;
   assign in_iccm = (addr_q & CCM_MASK) == ICCM_BASE;

   // ICCM accesses and DCCM writes must be word or doubleword
   assign size_err = (in_iccm | (in_dccm & write_q)) &
                     ((size_q == HSIZE_BYTE) | (size_q == HSIZE_HALF));

   // Natural alignment per size
   always_comb begin
      case (size_q)
         HSIZE_HALF:  align_err = addr_q[0];
         HSIZE_WORD:  align_err = |addr_q[1:0];
         HSIZE_DWORD: align_err = |addr_q[2:0];
         default:     align_err = 1'b0;       // Bytes are always aligned
      endcase
   end

   assign addr_err = (htrans_q != HTRANS_IDLE) &
                     (~(in_dccm | in_iccm) | size_err | align_err);

   // ***********************************************************
   // Write strobes
   // ***********************************************************
   // Lane pattern shifted up to the byte offset in the doubleword
   always_comb begin
      case (size_q)
         HSIZE_BYTE:  wstrb = wstrb_t'(8'h01) << addr_q[2:0];
         HSIZE_HALF:  wstrb = wstrb_t'(8'h03) << addr_q[2:0];
         HSIZE_WORD:  wstrb = wstrb_t'(8'h0F) << addr_q[2:0];
         HSIZE_DWORD: wstrb = 8'hFF;           // All lanes
         default:     wstrb = 8'h00;
      endcase
   end

endmodule

// File: ahb_axi_pkg.sv
// Shared bus types, transfer codes and CCM address map for the AHB-Lite to AXI4 bridge
package ahb_axi_pkg;

   // ***********************************************************
   // Bus field types
   // ***********************************************************
   typedef logic [31:0] haddr_t;     // AHB and AXI byte address
   typedef logic [2:0]  hsize_t;     // Transfer size code
   typedef logic [1:0]  htrans_t;    // AHB transfer type
   typedef logic [63:0] bus_data_t;  // Read or write data
   typedef logic [7:0]  wstrb_t;     // One strobe per data byte
   typedef logic [1:0]  axi_resp_t;  // AXI response where nonzero is an error

   // ***********************************************************
   // Transfer codes
   // ***********************************************************
   // Size codes as log2 of the byte count
   localparam hsize_t HSIZE_BYTE  = 3'd0;
   localparam hsize_t HSIZE_HALF  = 3'd1;
   localparam hsize_t HSIZE_WORD  = 3'd2;
   localparam hsize_t HSIZE_DWORD = 3'd3;

   // Transfer types seen on htrans
   localparam htrans_t HTRANS_IDLE   = 2'b00;
   localparam htrans_t HTRANS_BUSY   = 2'b01;  // Only used for write hold-off
   localparam htrans_t HTRANS_NONSEQ = 2'b10;  // Every real transfer is single

   // ***********************************************************
   // CCM address map
   // ***********************************************************
   localparam haddr_t DCCM_BASE      = 32'hF004_0000;
   localparam haddr_t ICCM_BASE      = 32'hEE00_0000;
   localparam haddr_t CCM_SIZE_BYTES = 32'h0001_0000;  // 64 KB per window

   // Windows are aligned to their size
   // So a masked compare against the base decodes them
   localparam haddr_t CCM_MASK = ~(CCM_SIZE_BYTES - 32'd1);

endpackage
